//--- include/ciHub_cfg.svh
`ifndef CIHUB_CFG_SVH
`define CIHUB_CFG_SVH

// Custom-instruction operand and result width
`define CI_WIDTH 32

// Release comes when the top bit sets 16 cycles after lock
`define RESET_COUNT_WIDTH 5

// One microsecond is 10 cycles of the 100 ns simulation clock
`define CYCLES_PER_MICROSECOND 10
`define DELAY_COUNT_WIDTH 32

// Grayscale weights summing to 256
`define GRAY_WEIGHT_RED 54
`define GRAY_WEIGHT_GREEN 183
`define GRAY_WEIGHT_BLUE 19

`endif

//--- verilog/ciPackage.sv
`include "ciHub_cfg.svh"

package ciPackage;

  // Custom-instruction numbers seen on ciN
  typedef enum logic [7:0] {
    ciSwapByte  = 8'd1,
    ciDelay     = 8'd6,
    ciGrayscale = 8'd13
  } ciOpcode;

  typedef enum logic [1:0] {
    idle,
    waiting,
    finish
  } delayState;

  // Operand and result word
  typedef logic [`CI_WIDTH-1:0] ciWord;

endpackage

//--- verilog/resetSequencer.sv
`timescale 1ns/10ps
`include "ciHub_cfg.svh"

module resetSequencer (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic cpuReady,
  output logic cpuReset
);

  logic [`RESET_COUNT_WIDTH-1:0] resetCount;

  // Counts up after lock and holds once the top bit is set
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      resetCount <= '0;
    end else if (!resetCount[`RESET_COUNT_WIDTH-1]) begin
      resetCount <= resetCount + 1'b1;
    end
  end

  assign cpuReady = resetCount[`RESET_COUNT_WIDTH-1];
  assign cpuReset = ~cpuReady;  // Held until the count completes

  // Once released, the CPU stays out of reset while the PLL holds lock
  assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    cpuReady |=> cpuReady)
    else $error("resetSequencer: cpuReady dropped while PLL locked");

endmodule

//--- verilog/microsecondTimer.sv
`timescale 1ns/10ps
`include "ciHub_cfg.svh"

module microsecondTimer import ciPackage::*; (
  input  logic  s_systemClock,
  input  logic  s_pllLocked,
  input  logic  cpuReset,
  input  logic  loadTimer,
  input  ciWord loadValue,
  output logic  expired
);

  localparam int PRESCALE_WIDTH = $clog2(`CYCLES_PER_MICROSECOND);
  localparam logic [PRESCALE_WIDTH-1:0] FIRST_TICK = PRESCALE_WIDTH'(1);
  localparam logic [PRESCALE_WIDTH-1:0] LAST_TICK =
    PRESCALE_WIDTH'(`CYCLES_PER_MICROSECOND - 1);

  logic [PRESCALE_WIDTH-1:0]     prescaleCount;
  logic [`DELAY_COUNT_WIDTH-1:0] remainingCount;

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      prescaleCount  <= '0;
      remainingCount <= '0;
    end else if (cpuReset) begin
      prescaleCount  <= '0;
      remainingCount <= '0;
    end else if (loadTimer) begin
      // The load cycle itself is tick 0 of the first microsecond
      prescaleCount  <= FIRST_TICK;
      remainingCount <= loadValue;
    end else if (remainingCount != '0) begin
      if (prescaleCount == LAST_TICK) begin
        prescaleCount  <= '0;
        remainingCount <= remainingCount - 1'b1;  // One microsecond gone
      end else begin
        prescaleCount <= prescaleCount + 1'b1;
      end
    end
  end

  // Never reports done in the cycle a new delay is loaded
  assign expired = (remainingCount == '0) && !loadTimer;

  // An idle timer stays at zero until the next load
  assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    (remainingCount == '0) && !loadTimer |=> remainingCount == '0)
    else $error("microsecondTimer: count wrapped below zero");

endmodule

//--- verilog/delaySequencer.sv
`timescale 1ns/10ps

module delaySequencer import ciPackage::*; (
  input  logic    s_systemClock,
  input  logic    s_pllLocked,
  input  logic    cpuReset,
  input  logic    ciStart,
  input  ciOpcode ciN,
  input  ciWord   ciDataA,
  input  logic    expired,
  output logic    loadTimer,
  output ciWord   loadValue,
  output logic    ciDone,
  output ciWord   ciResult
);

  delayState currentState;
  delayState nextState;
  logic      startDelay;
  logic      doneReg;

  assign startDelay = ciStart && (ciN == ciDelay) && (currentState == idle);

  assign loadTimer = startDelay;
  assign loadValue = ciDataA;  // Sampled by the timer only on a load

  always_comb begin
    nextState = currentState;
    case (currentState)
      idle: begin
        // Zero delay skips the timer
        if (startDelay) begin
          nextState = (ciDataA == '0) ? finish : waiting;
        end
      end
      waiting: begin
        if (expired) begin
          nextState = finish;
        end
      end
      finish:  nextState = idle;
      default: nextState = idle;
    endcase
  end

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      currentState <= idle;
      doneReg      <= 1'b0;
    end else if (cpuReset) begin
      currentState <= idle;
      doneReg      <= 1'b0;
    end else begin
      currentState <= nextState;
      doneReg      <= (nextState == finish);  // High for the one cycle in finish
    end
  end

  assign ciDone   = doneReg;
  assign ciResult = '0;  // Delay returns no value

  // CPU must wait for ciDone before issuing the next instruction
  assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    ciStart |-> currentState == idle)
    else $error("delaySequencer: ciStart in state %s", currentState.name());

endmodule

//--- verilog/byteSwapper.sv
`timescale 1ns/10ps
`include "ciHub_cfg.svh"

module byteSwapper import ciPackage::*; (
  input  logic    ciStart,
  input  ciOpcode ciN,
  input  ciWord   ciDataA,
  input  ciWord   ciDataB,
  output logic    ciDone,
  output ciWord   ciResult
);

  localparam int BYTE_COUNT = `CI_WIDTH / 8;

  logic  selected;
  ciWord reversedWord;
  ciWord halfSwappedWord;

  assign selected = ciStart && (ciN == ciSwapByte);

  always_comb begin
    for (int i = 0; i < BYTE_COUNT; i++) begin
      reversedWord[8*i +: 8]    = ciDataA[8*(BYTE_COUNT-1-i) +: 8];
      halfSwappedWord[8*i +: 8] = ciDataA[8*(i ^ 1) +: 8];  // Swap within each half-word
    end
  end

  // Bit 0 of operand B picks the swap mode
  assign ciDone   = selected;
  assign ciResult = !selected   ? '0 :
                    ciDataB[0] ? halfSwappedWord : reversedWord;

endmodule

//--- verilog/grayscaleConverter.sv
`timescale 1ns/10ps
`include "ciHub_cfg.svh"

module grayscaleConverter import ciPackage::*; (
  input  logic    ciStart,
  input  ciOpcode ciN,
  input  ciWord   ciDataA,
  output logic    ciDone,
  output ciWord   ciResult
);

  logic        selected;
  logic [7:0]  red;
  logic [7:0]  green;
  logic [7:0]  blue;
  logic [15:0] weightedSum;
  logic [7:0]  grayLevel;

  assign selected = ciStart && (ciN == ciGrayscale);

  // RGB565 fields widened to 8 bits with zero low bits
  assign red   = {ciDataA[15:11], 3'b000};
  assign green = {ciDataA[10:5], 2'b00};
  assign blue  = {ciDataA[4:0], 3'b000};

  // Weights sum to 256, so the top byte is the gray level
  assign weightedSum = 16'(`GRAY_WEIGHT_RED) * {8'd0, red} +
                       16'(`GRAY_WEIGHT_GREEN) * {8'd0, green} +
                       16'(`GRAY_WEIGHT_BLUE) * {8'd0, blue};

  assign grayLevel = weightedSum[15:8];

  assign ciDone   = selected;
  assign ciResult = selected ? {{(`CI_WIDTH-8){1'b0}}, grayLevel} : '0;

endmodule

//--- verilog/ciHub.sv
`timescale 1ns/10ps

module ciHub import ciPackage::*; (
  input  logic    s_systemClock,
  input  logic    s_pllLocked,
  input  logic    ciStart,
  input  ciOpcode ciN,
  input  ciWord   ciDataA,
  input  ciWord   ciDataB,
  output logic    cpuReady,
  output logic    ciDone,
  output ciWord   ciResult
);

  logic  cpuReset;
  logic  loadTimer;
  ciWord loadValue;
  logic  timerExpired;
  logic  swapDone;
  ciWord swapResult;
  logic  delayDone;
  ciWord delayResult;
  logic  grayDone;
  ciWord grayResult;

  resetSequencer resetSeq (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .cpuReady     (cpuReady),
    .cpuReset     (cpuReset)
  );

  microsecondTimer usTimer (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .cpuReset     (cpuReset),
    .loadTimer    (loadTimer),
    .loadValue    (loadValue),
    .expired      (timerExpired)
  );

  // Opcode 6 blocks for a number of microseconds
  delaySequencer delayUnit (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .cpuReset     (cpuReset),
    .ciStart      (ciStart),
    .ciN          (ciN),
    .ciDataA      (ciDataA),
    .expired      (timerExpired),
    .loadTimer    (loadTimer),
    .loadValue    (loadValue),
    .ciDone       (delayDone),
    .ciResult     (delayResult)
  );

  byteSwapper swapUnit (
    .ciStart (ciStart),
    .ciN     (ciN),
    .ciDataA (ciDataA),
    .ciDataB (ciDataB),
    .ciDone  (swapDone),
    .ciResult(swapResult)
  );

  grayscaleConverter grayUnit (
    .ciStart (ciStart),
    .ciN     (ciN),
    .ciDataA (ciDataA),
    .ciDone  (grayDone),
    .ciResult(grayResult)
  );

  // Unselected units drive zero, so OR merges cleanly
  assign ciDone   = swapDone | delayDone | grayDone;
  assign ciResult = swapResult | delayResult | grayResult;

endmodule

//--- tests/ciHubTb.sv
`timescale 1ns/10ps
`include "ciHub_cfg.svh"

module ciHubTb import ciPackage::*; ();

  localparam int HALF_PERIOD    = 50;
  localparam int SAMPLE_DELAY   = 25;  // Quarter period after the falling edge
  localparam int RANDOM_COUNT   = 32;
  localparam int NO_DONE_WAIT   = 50;
  localparam int RELEASE_CYCLES = 1 << (`RESET_COUNT_WIDTH - 1);

  logic    s_systemClock = 1'b0;
  logic    s_pllLocked;
  logic    ciStart;
  ciOpcode ciN;
  ciWord   ciDataA;
  ciWord   ciDataB;
  logic    cpuReady;
  logic    ciDone;
  ciWord   ciResult;

  logic [7:0]  patternOp[$];
  ciWord       patternA[$];
  ciWord       patternB[$];
  ciWord       patternResult[$];
  int          patternLatency[$];  // -1 means no ciDone expected
  logic [31:0] lfsrState = 32'hbfa0_7038;
  int          cycleCount = 0;
  int          cycleLimit = 0;

  ciHub dut0 (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .ciStart      (ciStart),
    .ciN          (ciN),
    .ciDataA      (ciDataA),
    .ciDataB      (ciDataB),
    .cpuReady     (cpuReady),
    .ciDone       (ciDone),
    .ciResult     (ciResult)
  );

  always #(HALF_PERIOD) s_systemClock = ~s_systemClock;

  initial begin
    wait (cycleLimit > 0);
    while (cycleCount < cycleLimit) begin
      @(posedge s_systemClock);
      cycleCount++;
    end
    $display("timeout: the tests did not finish within %0d clock cycles", cycleLimit);
    $display("ERRORS FOUND");
    $fatal(1, "run stopped by timeout");
  end

  function automatic logic [31:0] lfsrStep(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'hD000_0001) : (state >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic ciWord randomBits(input int count);
    ciWord value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsrState = lfsrStep(lfsrState);
      value = {value[`CI_WIDTH-2:0], lfsrState[0]};
    end
    return value;
  endfunction

  function automatic ciWord swapModel(input ciWord a, input ciWord b);
    if (b[0]) begin
      return {a[23:16], a[31:24], a[7:0], a[15:8]};
    end
    return {a[7:0], a[15:8], a[23:16], a[31:24]};
  endfunction

  function automatic ciWord grayModel(input ciWord a);
    int red;
    int green;
    int blue;
    int sum;
    red   = int'(a[15:11]) * 8;
    green = int'(a[10:5]) * 4;
    blue  = int'(a[4:0]) * 8;
    sum   = `GRAY_WEIGHT_RED * red + `GRAY_WEIGHT_GREEN * green + `GRAY_WEIGHT_BLUE * blue;
    return ciWord'(sum / 256);
  endfunction

  task automatic checkWord(input string signalName, input ciWord expected, input ciWord actual);
    if (actual !== expected) begin
      $display("error at time %0t: %s expected %h, got %h", $time, signalName, expected, actual);
      $display("ERRORS FOUND");
      $fatal(1, "word mismatch");
    end
  endtask

  task automatic compareLatency(input string signalName, input int expected, input int actual);
    if (actual != expected) begin
      $display("error at time %0t: %s expected %0d cycles, got %0d cycles",
               $time, signalName, expected, actual);
      $display("ERRORS FOUND");
      $fatal(1, "latency mismatch");
    end
  endtask

  task automatic verifyLevel(input string signalName, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("error at time %0t: %s expected %b, got %b", $time, signalName, expected, actual);
      $display("ERRORS FOUND");
      $fatal(1, "level mismatch");
    end
  endtask

  task automatic confirmState(input string signalName, input delayState expected,
                              input delayState actual);
    if (actual !== expected) begin
      $display("error at time %0t: %s expected %s, got %s",
               $time, signalName, expected.name(), actual.name());
      $display("ERRORS FOUND");
      $fatal(1, "state mismatch");
    end
  endtask

  task automatic readPatterns();
    int          fd;
    int          fields;
    int          latency;
    string       lineText;
    logic [7:0]  op;
    ciWord       a;
    ciWord       b;
    ciWord       expected;
    fd = $fopen("tests/ciHub_patterns.txt", "r");
    if (fd == 0) begin
      $display("could not open the pattern file tests/ciHub_patterns.txt");
      $display("ERRORS FOUND");
      $fatal(1, "missing pattern file");
    end
    while (!$feof(fd)) begin
      lineText = "";
      fields = $fgets(lineText, fd);
      if (fields > 0 && lineText.len() > 0 && lineText[0] != "#") begin
        fields = $sscanf(lineText, "%h %h %h %h %d", op, a, b, expected, latency);
        if (fields == 5) begin
          patternOp.push_back(op);
          patternA.push_back(a);
          patternB.push_back(b);
          patternResult.push_back(expected);
          patternLatency.push_back(latency);
        end
      end
    end
    $fclose(fd);
    if (patternOp.size() == 0) begin
      $display("the pattern file holds no usable lines");
      $display("ERRORS FOUND");
      $fatal(1, "empty pattern file");
    end
  endtask

  // Random swap and grayscale operands after the file patterns
  task automatic addRandomPatterns();
    ciWord pick;
    ciWord a;
    ciWord b;
    for (int k = 0; k < RANDOM_COUNT; k++) begin
      pick = randomBits(1);
      a    = randomBits(`CI_WIDTH);
      b    = randomBits(`CI_WIDTH);
      patternA.push_back(a);
      patternB.push_back(b);
      patternLatency.push_back(0);
      if (pick[0]) begin
        patternOp.push_back(8'(ciSwapByte));
        patternResult.push_back(swapModel(a, b));
      end else begin
        patternOp.push_back(8'(ciGrayscale));
        patternResult.push_back(grayModel(a));
      end
    end
  endtask

  task automatic watchReset();
    repeat (5) begin
      @(negedge s_systemClock);
      verifyLevel("cpuReady", 1'b0, cpuReady);
      verifyLevel("ciDone", 1'b0, ciDone);
    end
    confirmState("delayUnit.currentState", idle, dut0.delayUnit.currentState);
    s_pllLocked = 1'b1;
    for (int i = 1; i <= RELEASE_CYCLES; i++) begin
      @(negedge s_systemClock);  // One rising edge since the last check
      verifyLevel("cpuReady", i == RELEASE_CYCLES, cpuReady);
      verifyLevel("ciDone", 1'b0, ciDone);
    end
  endtask

  task automatic issueInstruction(input logic [7:0] opcode, input ciWord a, input ciWord b,
                                  input int waitLimit, output int latency,
                                  output logic doneSeen, output ciWord result);
    @(negedge s_systemClock);
    ciStart = 1'b1;
    ciN     = ciOpcode'(opcode);
    ciDataA = a;
    ciDataB = b;
    latency = 0;
    #(SAMPLE_DELAY);
    while (!ciDone && latency < waitLimit) begin
      checkWord("ciResult", '0, ciResult);  // Zero until done
      @(negedge s_systemClock);
      ciStart = 1'b0;
      latency++;
      #(SAMPLE_DELAY);
    end
    doneSeen = ciDone;
    result   = ciResult;
    @(negedge s_systemClock);
    ciStart = 1'b0;
    #(SAMPLE_DELAY);
    verifyLevel("ciDone", 1'b0, ciDone);  // Done lasts one cycle
  endtask

  task automatic runPattern(input int index);
    int    expectedLatency;
    int    waitLimit;
    int    latency;
    logic  doneSeen;
    ciWord result;
    expectedLatency = patternLatency[index];
    waitLimit = (expectedLatency >= 0) ? expectedLatency + 20 : NO_DONE_WAIT;
    issueInstruction(patternOp[index], patternA[index], patternB[index], waitLimit,
                     latency, doneSeen, result);
    if (expectedLatency < 0) begin
      verifyLevel("ciDone", 1'b0, doneSeen);
    end else begin
      verifyLevel("ciDone", 1'b1, doneSeen);
      compareLatency("ciDone latency", expectedLatency, latency);
    end
    checkWord("ciResult", patternResult[index], result);
    confirmState("delayUnit.currentState", idle, dut0.delayUnit.currentState);
  endtask

  initial begin
    int limit;
    s_pllLocked = 1'b0;
    ciStart     = 1'b0;
    ciN         = ciSwapByte;
    ciDataA     = '0;
    ciDataB     = '0;
    readPatterns();
    addRandomPatterns();
    limit = 100;
    foreach (patternLatency[i]) begin
      limit += 20 + ((patternLatency[i] >= 0) ? patternLatency[i] : NO_DONE_WAIT);
    end
    cycleLimit = limit;
    watchReset();
    for (int i = 0; i < patternOp.size(); i++) begin
      runPattern(i);
    end
    $display("NO ERRORS");
    $finish;
  end

endmodule

//--- tests/ciHub_patterns.txt
# Columns: opcode dataA dataB expectedResult (all hex), then latency in cycles (decimal)
# Latency -1 means the opcode is unassigned and no ciDone may come
01 12345678 00000000 78563412 0
01 12345678 00000001 34127856 0
01 deadbeef 00000000 efbeadde 0
01 deadbeef 00000003 addeefbe 0
01 deadbeef fffffffe efbeadde 0
01 00000000 00000001 00000000 0
0d 0000ffff 00000000 000000fa 0
0d 00000000 00000000 00000000 0
0d 0000f800 00000000 00000034 0
0d 000007e0 00000000 000000b4 0
0d 0000001f 00000000 00000012 0
0d abcd1234 00000000 0000003f 0
0d ffff0000 00000000 00000000 0
06 00000000 00000000 00000000 1
06 00000001 00000000 00000000 11
06 00000003 00000000 00000000 31
09 12345678 00000000 00000000 -1
01 a1b2c3d4 00000000 d4c3b2a1 0
ff 00000005 00000000 00000000 -1
06 00000002 12345678 00000000 21
0d 0000ffff 00000000 000000fa 0

//--- flist.f
+incdir+include
verilog/ciPackage.sv
verilog/resetSequencer.sv
verilog/microsecondTimer.sv
verilog/delaySequencer.sv
verilog/byteSwapper.sv
verilog/grayscaleConverter.sv
verilog/ciHub.sv
tests/ciHubTb.sv

//--- run.sh
#!/bin/sh
# Builds ciHubTb with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module ciHubTb -f flist.f -o ciHubSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/ciHubSim > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if grep -q "ERRORS FOUND" "$LOG"; then
  echo "simulation failed, see $LOG"
  exit 1
fi

if [ $simStatus -ne 0 ]; then
  echo "simulator exited with status $simStatus"
  exit 1
fi

echo "simulation passed"
exit 0
